/* source/cache_pkg.sv */
// Widths and payload types shared by the direct-mapped write-through cache bank.
// Modules that use these take them in with a wildcard import in their header.
package cache_pkg;

    localparam int WORD_BITS      = 32;
    localparam int LINE_WORDS     = 4;
    localparam int LINE_ADDR_BITS = 12;

    typedef logic [WORD_BITS-1:0]                 word_t;
    typedef logic [LINE_WORDS-1:0][WORD_BITS-1:0] line_t;
    typedef logic [LINE_ADDR_BITS-1:0]            line_addr_t;
    typedef logic [$clog2(LINE_WORDS)-1:0]        wsel_t;
    typedef logic [WORD_BITS/8-1:0]               byteen_t;
    typedef logic [7:0]                           req_tag_t;

    // operation kind carried down the pipeline
    typedef enum logic [1:0] {
        OP_READ,
        OP_WRITE,
        OP_FILL,
        OP_REPLAY
    } op_t;

    typedef struct packed {
        req_tag_t tag;
        word_t    data;
    } core_rsp_t;

    typedef struct packed {
        logic       rw;
        line_addr_t addr;
        wsel_t      wsel;
        byteen_t    byteen;
        word_t      data;
    } mem_req_t;

    typedef struct packed {
        line_addr_t addr;
        wsel_t      wsel;
        req_tag_t   tag;
    } miss_entry_t;

endpackage

/* source/cache_fifo.sv */
// Synchronous FIFO with a type-parameter payload.
// A push shows at data_out one cycle later; alm_full is raised once the
// count reaches ALM_FULL so a producer can stop early.
`timescale 1ns/1ps

module cache_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4,
    parameter int  ALM_FULL  = DEPTH - 1
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  logic     pop,
    input  payload_t data_in,
    output payload_t data_out,
    output logic     empty,
    output logic     full,
    output logic     alm_full
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    payload_t            mem_q [DEPTH];
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS-1:0] wr_ptr;
    logic [CNT_BITS-1:0] count;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_BITS'(push) - CNT_BITS'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem_q[wr_ptr] <= data_in;
        end
    end

    assign data_out = mem_q[rd_ptr];
    assign empty    = (count == '0);
    assign full     = (count == CNT_BITS'(DEPTH));
    assign alm_full = (count >= CNT_BITS'(ALM_FULL));

    assert property (@(posedge clk) disable iff (!rst_n) !(push && full));
    assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty));

endmodule

/* source/cache_tags.sv */
// Valid and tag store of the direct-mapped bank.
// Lookup is combinational from the stage-0 address; a fill from stage 1
// sets the valid bit and writes the tag of its line.
`timescale 1ns/1ps

module cache_tags import cache_pkg::*; #(
    parameter int NUM_LINES = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    input  line_addr_t lookup_addr,
    input  logic       fill,
    input  line_addr_t fill_addr,
    output logic       hit
);

    localparam int INDEX_BITS = $clog2(NUM_LINES);
    localparam int TAG_BITS   = LINE_ADDR_BITS - INDEX_BITS;

    logic [NUM_LINES-1:0]  valid_q;
    logic [TAG_BITS-1:0]   tag_q [NUM_LINES];
    logic [INDEX_BITS-1:0] lookup_idx;
    logic [INDEX_BITS-1:0] fill_idx;
    logic [TAG_BITS-1:0]   lookup_tag;
    logic [TAG_BITS-1:0]   fill_tag;

    assign lookup_idx = lookup_addr[INDEX_BITS-1:0];
    assign lookup_tag = lookup_addr[LINE_ADDR_BITS-1:INDEX_BITS];
    assign fill_idx   = fill_addr[INDEX_BITS-1:0];
    assign fill_tag   = fill_addr[LINE_ADDR_BITS-1:INDEX_BITS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (fill) begin
            valid_q[fill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[fill_idx] <= fill_tag;
        end
    end

    // a fill landing this cycle wins over the stored entry
    assign hit = (fill && (fill_idx == lookup_idx)) ? (fill_tag == lookup_tag)
               : (valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag));

endmodule

/* source/cache_data.sv */
// Line data store of the direct-mapped bank, accessed in stage 1.
// A fill replaces a whole line, a write merges enabled bytes into one word,
// and read_data returns the selected word of the addressed line.
`timescale 1ns/1ps

module cache_data import cache_pkg::*; #(
    parameter int NUM_LINES = 16
) (
    input  logic       clk,
    input  line_addr_t addr,
    input  wsel_t      wsel,
    input  byteen_t    byteen,
    input  logic       write,
    input  word_t      write_data,
    input  logic       fill,
    input  line_t      fill_data,
    output word_t      read_data
);

    localparam int INDEX_BITS = $clog2(NUM_LINES);

    line_t                 lines [NUM_LINES];
    logic [INDEX_BITS-1:0] idx;

    assign idx = addr[INDEX_BITS-1:0];

    always_ff @(posedge clk) begin
        if (fill) begin
            lines[idx] <= fill_data;
        end else if (write) begin
            for (int b = 0; b < WORD_BITS / 8; b++) begin
                if (byteen[b]) begin
                    lines[idx][wsel][b*8 +: 8] <= write_data[b*8 +: 8];
                end
            end
        end
    end

    assign read_data = lines[idx][wsel];

    // one stage-1 operation per cycle
    assert property (@(posedge clk) !(write && fill));

endmodule

/* source/cache_miss_tracker.sv */
// Tracks core requests in flight and parked read misses.
// Credits bound the requests between acceptance and completion. Misses wait
// in order; after the matching fill passes stage 1 the head is offered
// for replay, and only one fill is outstanding until that replay is taken.
`timescale 1ns/1ps

module cache_miss_tracker import cache_pkg::*; #(
    parameter int MSHR_DEPTH = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        core_req_fire,
    input  logic        allocate,
    input  miss_entry_t alloc_entry,
    input  logic        retire,
    input  logic        fill_fire,
    input  logic        fill_done,
    input  logic        replay_ready,
    output logic        credit_full,
    output logic        miss_empty,
    output logic        fill_busy,
    output line_addr_t  fill_addr,
    output logic        replay_valid,
    output miss_entry_t replay_entry
);

    localparam int CNT_BITS = $clog2(MSHR_DEPTH + 1);

    logic [CNT_BITS-1:0] credit_cnt;
    logic                fill_ready_q;
    logic                fill_busy_q;
    logic                replay_fire;
    logic                queue_empty;
    miss_entry_t         head;

    cache_fifo #(
        .payload_t (miss_entry_t),
        .DEPTH     (MSHR_DEPTH),
        .ALM_FULL  (MSHR_DEPTH)
    ) miss_queue (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (allocate),
        .pop      (replay_fire),
        .data_in  (alloc_entry),
        .data_out (head),
        .empty    (queue_empty),
        .full     (),
        .alm_full ()
    );

    assign replay_fire = replay_valid && replay_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_cnt   <= '0;
            fill_ready_q <= 1'b0;
            fill_busy_q  <= 1'b0;
        end else begin
            credit_cnt <= credit_cnt + CNT_BITS'(core_req_fire)
                        - CNT_BITS'(retire) - CNT_BITS'(replay_fire);
            if (fill_done) begin
                fill_ready_q <= 1'b1;
            end else if (replay_fire) begin
                fill_ready_q <= 1'b0;
            end
            if (fill_fire) begin
                fill_busy_q <= 1'b1;
            end else if (replay_fire) begin
                fill_busy_q <= 1'b0;
            end
        end
    end

    assign credit_full  = (credit_cnt == CNT_BITS'(MSHR_DEPTH));
    assign miss_empty   = queue_empty;
    assign fill_busy    = fill_busy_q;
    // memory answers in order, so the head names the line being filled
    assign fill_addr    = head.addr;
    assign replay_valid = fill_ready_q;
    assign replay_entry = head;

    assert property (@(posedge clk) disable iff (!rst_n)
        (credit_cnt == '0) |-> !(retire || replay_fire));

endmodule

/* source/cache_bank.sv */
// Single-port direct-mapped write-through cache bank, no write-allocate.
// Requests are arbitrated replay first, then memory fill, then core request,
// and pass a tag lookup stage and a data/decision stage. Read misses park in
// the miss tracker and replay after their fill; writes go through to memory.
`timescale 1ns/1ps

module cache_bank import cache_pkg::*; #(
    parameter int NUM_LINES  = 16,
    parameter int MSHR_DEPTH = 4,
    parameter int CRSQ_DEPTH = 4,
    parameter int MREQ_DEPTH = 4
) (
    input  logic       clk,
    input  logic       rst_n,

    input  logic       core_req_valid,
    input  logic       core_req_rw,
    input  line_addr_t core_req_addr,
    input  wsel_t      core_req_wsel,
    input  byteen_t    core_req_byteen,
    input  word_t      core_req_data,
    input  req_tag_t   core_req_tag,
    output logic       core_req_ready,

    output logic       core_rsp_valid,
    output word_t      core_rsp_data,
    output req_tag_t   core_rsp_tag,
    input  logic       core_rsp_ready,

    output logic       mem_req_valid,
    output logic       mem_req_rw,
    output line_addr_t mem_req_addr,
    output wsel_t      mem_req_wsel,
    output byteen_t    mem_req_byteen,
    output word_t      mem_req_data,
    input  logic       mem_req_ready,

    input  logic       mem_rsp_valid,
    input  line_t      mem_rsp_data,
    output logic       mem_rsp_ready
);

    localparam int PIPELINE_STAGES = 2;

    logic        active_q;
    logic        pipe_stall;
    logic        credit_full;
    logic        miss_empty;
    logic        fill_busy;
    logic        replay_valid;
    logic        replay_ready;
    miss_entry_t replay_entry;
    miss_entry_t alloc_entry;
    line_addr_t  fill_addr;
    logic        fill_enable;
    logic        replay_fire;
    logic        fill_fire;
    logic        core_req_fire;
    logic        rd_in_pipe;
    logic        valid_sel;
    op_t         op_sel;
    line_addr_t  addr_sel;
    wsel_t       wsel_sel;
    req_tag_t    tag_sel;
    line_t       data_sel;

    logic        valid_st0;
    op_t         op_st0;
    line_addr_t  addr_st0;
    wsel_t       wsel_st0;
    byteen_t     byteen_st0;
    req_tag_t    tag_st0;
    line_t       data_st0;
    logic        tag_hit;
    logic        lookup_st0;

    logic        valid_st1;
    op_t         op_st1;
    line_addr_t  addr_st1;
    wsel_t       wsel_st1;
    byteen_t     byteen_st1;
    req_tag_t    tag_st1;
    line_t       data_st1;
    logic        hit_st1;
    word_t       read_data_st1;

    logic        do_read_st1;
    logic        do_write_st1;
    logic        do_fill_st1;
    logic        do_replay_st1;
    logic        rsp_push;
    logic        miss_st1;
    logic        retire;
    core_rsp_t   crsq_in;
    core_rsp_t   crsq_out;
    logic        crsq_empty;
    logic        crsq_full;
    mem_req_t    mreq_in;
    mem_req_t    mreq_out;
    logic        mreq_push;
    logic        mreq_empty;
    logic        mreq_alm_full;

    // holds every ready low until the first cycle out of reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active_q <= 1'b0;
        end else begin
            active_q <= 1'b1;
        end
    end

    // write may not overtake a read miss still waiting for its line
    assign rd_in_pipe = (valid_st0 && (op_st0 == OP_READ))
                     || (valid_st1 && (op_st1 == OP_READ));

    assign fill_enable    = mem_rsp_valid && !replay_valid && !fill_busy;
    assign replay_ready   = !pipe_stall;
    assign mem_rsp_ready  = active_q && !replay_valid && !fill_busy && !pipe_stall;
    assign core_req_ready = active_q && !replay_valid && !fill_enable && !credit_full
                         && !mreq_alm_full && !pipe_stall
                         && (!core_req_rw || (miss_empty && !rd_in_pipe));

    assign replay_fire   = replay_valid && replay_ready;
    assign fill_fire     = mem_rsp_valid && mem_rsp_ready;
    assign core_req_fire = core_req_valid && core_req_ready;
    assign valid_sel     = replay_fire || fill_fire || core_req_fire;

    always_comb begin
        if (replay_valid) begin
            op_sel   = OP_REPLAY;
            addr_sel = replay_entry.addr;
        end else if (fill_enable) begin
            op_sel   = OP_FILL;
            addr_sel = fill_addr;
        end else begin
            op_sel   = core_req_rw ? OP_WRITE : OP_READ;
            addr_sel = core_req_addr;
        end
        wsel_sel = replay_valid ? replay_entry.wsel : core_req_wsel;
        tag_sel  = replay_valid ? replay_entry.tag : core_req_tag;
        data_sel = mem_rsp_data;
        if (!fill_enable) begin
            data_sel[0] = core_req_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_st0 <= 1'b0;
            valid_st1 <= 1'b0;
        end else if (!pipe_stall) begin
            valid_st0 <= valid_sel;
            valid_st1 <= valid_st0;
        end
    end

    always_ff @(posedge clk) begin
        if (!pipe_stall) begin
            op_st0     <= op_sel;
            addr_st0   <= addr_sel;
            wsel_st0   <= wsel_sel;
            byteen_st0 <= core_req_byteen;
            tag_st0    <= tag_sel;
            data_st0   <= data_sel;
            op_st1     <= op_st0;
            addr_st1   <= addr_st0;
            wsel_st1   <= wsel_st0;
            byteen_st1 <= byteen_st0;
            tag_st1    <= tag_st0;
            data_st1   <= data_st0;
            hit_st1    <= lookup_st0 && tag_hit;
        end
    end

    assign lookup_st0 = valid_st0 && (op_st0 != OP_FILL);

    cache_tags #(
        .NUM_LINES (NUM_LINES)
    ) tags (
        .clk         (clk),
        .rst_n       (rst_n),
        .lookup_addr (addr_st0),
        .fill        (do_fill_st1),
        .fill_addr   (addr_st1),
        .hit         (tag_hit)
    );

    assign do_read_st1   = valid_st1 && (op_st1 == OP_READ);
    assign do_write_st1  = valid_st1 && (op_st1 == OP_WRITE);
    assign do_fill_st1   = valid_st1 && (op_st1 == OP_FILL);
    assign do_replay_st1 = valid_st1 && (op_st1 == OP_REPLAY);

    assign rsp_push   = (do_read_st1 && hit_st1) || do_replay_st1;
    assign pipe_stall = rsp_push && crsq_full;
    assign miss_st1   = do_read_st1 && !hit_st1;
    assign retire     = (do_read_st1 && hit_st1 && !pipe_stall) || do_write_st1;
    assign mreq_push  = miss_st1 || do_write_st1;

    cache_data #(
        .NUM_LINES (NUM_LINES)
    ) data (
        .clk        (clk),
        .addr       (addr_st1),
        .wsel       (wsel_st1),
        .byteen     (byteen_st1),
        .write      (do_write_st1 && hit_st1),
        .write_data (data_st1[0]),
        .fill       (do_fill_st1),
        .fill_data  (data_st1),
        .read_data  (read_data_st1)
    );

    assign alloc_entry = '{addr: addr_st1, wsel: wsel_st1, tag: tag_st1};

    cache_miss_tracker #(
        .MSHR_DEPTH (MSHR_DEPTH)
    ) miss_tracker (
        .clk           (clk),
        .rst_n         (rst_n),
        .core_req_fire (core_req_fire),
        .allocate      (miss_st1),
        .alloc_entry   (alloc_entry),
        .retire        (retire),
        .fill_fire     (fill_fire),
        .fill_done     (do_fill_st1),
        .replay_ready  (replay_ready),
        .credit_full   (credit_full),
        .miss_empty    (miss_empty),
        .fill_busy     (fill_busy),
        .fill_addr     (fill_addr),
        .replay_valid  (replay_valid),
        .replay_entry  (replay_entry)
    );

    // the replayed line was installed by the fill just ahead of it
    assert property (@(posedge clk) disable iff (!rst_n) do_replay_st1 |-> hit_st1);

    assign crsq_in = '{tag: tag_st1, data: read_data_st1};

    cache_fifo #(
        .payload_t (core_rsp_t),
        .DEPTH     (CRSQ_DEPTH)
    ) core_rsp_queue (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (rsp_push && !pipe_stall),
        .pop      (core_rsp_valid && core_rsp_ready),
        .data_in  (crsq_in),
        .data_out (crsq_out),
        .empty    (crsq_empty),
        .full     (crsq_full),
        .alm_full ()
    );

    assign core_rsp_valid = !crsq_empty;
    assign core_rsp_tag   = crsq_out.tag;
    assign core_rsp_data  = crsq_out.data;

    // line read for a miss, single word for a write-through
    assign mreq_in = '{
        rw:     do_write_st1,
        addr:   addr_st1,
        wsel:   wsel_st1,
        byteen: byteen_st1,
        data:   data_st1[0]
    };

    cache_fifo #(
        .payload_t (mem_req_t),
        .DEPTH     (MREQ_DEPTH),
        .ALM_FULL  (MREQ_DEPTH - PIPELINE_STAGES)
    ) mem_req_queue (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (mreq_push),
        .pop      (mem_req_valid && mem_req_ready),
        .data_in  (mreq_in),
        .data_out (mreq_out),
        .empty    (mreq_empty),
        .full     (),
        .alm_full (mreq_alm_full)
    );

    assign mem_req_valid  = !mreq_empty;
    assign mem_req_rw     = mreq_out.rw;
    assign mem_req_addr   = mreq_out.addr;
    assign mem_req_wsel   = mreq_out.wsel;
    assign mem_req_byteen = mreq_out.byteen;
    assign mem_req_data   = mreq_out.data;

endmodule

/* test/cache_bank_tb.sv */
// Testbench for the cache bank. A table of core reads and writes runs in
// order, each read marked with whether it must fetch its line from memory.
// The memory model answers line reads in order after random delays and
// applies write-throughs; read data is checked against a shadow memory.
`timescale 1ns/1ps

module cache_bank_tb import cache_pkg::*; ();

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 16;
    localparam int NUM_OPS       = 28;
    localparam int OP_CYCLES     = 64;
    localparam int NUM_MEM_LINES = 1 << LINE_ADDR_BITS;

    typedef struct packed {
        logic       rw;
        logic       fill;
        line_addr_t addr;
        wsel_t      wsel;
        byteen_t    be;
        word_t      data;
    } op_rec_t;

    logic       clk;
    logic       rst_n;
    logic       core_req_valid;
    logic       core_req_rw;
    line_addr_t core_req_addr;
    wsel_t      core_req_wsel;
    byteen_t    core_req_byteen;
    word_t      core_req_data;
    req_tag_t   core_req_tag;
    logic       core_req_ready;
    logic       core_rsp_valid;
    word_t      core_rsp_data;
    req_tag_t   core_rsp_tag;
    logic       core_rsp_ready;
    logic       mem_req_valid;
    logic       mem_req_rw;
    line_addr_t mem_req_addr;
    wsel_t      mem_req_wsel;
    byteen_t    mem_req_byteen;
    word_t      mem_req_data;
    logic       mem_req_ready;
    logic       mem_rsp_valid;
    line_t      mem_rsp_data;
    logic       mem_rsp_ready;

    op_rec_t    ops [NUM_OPS];
    int         n_ops;
    word_t      shadow [NUM_MEM_LINES][LINE_WORDS];
    word_t      exp_data [NUM_OPS];
    bit         issued [NUM_OPS];
    int         rsp_count [NUM_OPS];
    int         issued_reads;
    int         answered;
    int         fills_expected;
    int         writes_expected;
    int         seq_errors;
    int         data_errors;
    int         mem_errors;
    int         mem_reads;
    int         mem_writes;
    int         rd_pos;
    int         wr_pos;
    line_t      mem_lines [NUM_MEM_LINES];
    line_t      fill_q [$];
    logic [2:0] fill_wait;
    logic [31:0] lfsr;

    cache_bank #(
        .NUM_LINES  (16),
        .MSHR_DEPTH (4),
        .CRSQ_DEPTH (4),
        .MREQ_DEPTH (4)
    ) DUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .core_req_valid  (core_req_valid),
        .core_req_rw     (core_req_rw),
        .core_req_addr   (core_req_addr),
        .core_req_wsel   (core_req_wsel),
        .core_req_byteen (core_req_byteen),
        .core_req_data   (core_req_data),
        .core_req_tag    (core_req_tag),
        .core_req_ready  (core_req_ready),
        .core_rsp_valid  (core_rsp_valid),
        .core_rsp_data   (core_rsp_data),
        .core_rsp_tag    (core_rsp_tag),
        .core_rsp_ready  (core_rsp_ready),
        .mem_req_valid   (mem_req_valid),
        .mem_req_rw      (mem_req_rw),
        .mem_req_addr    (mem_req_addr),
        .mem_req_wsel    (mem_req_wsel),
        .mem_req_byteen  (mem_req_byteen),
        .mem_req_data    (mem_req_data),
        .mem_req_ready   (mem_req_ready),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp_data    (mem_rsp_data),
        .mem_rsp_ready   (mem_rsp_ready)
    );

    // initial memory contents, unique per line and word
    function automatic word_t pattern_word(line_addr_t line, int w);
        return {4'hc, 2'(w), line, 2'(w), ~line};
    endfunction

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic read_entry(line_addr_t addr, wsel_t wsel, logic fill);
        ops[n_ops] = '{rw: 1'b0, fill: fill, addr: addr, wsel: wsel, be: '0, data: '0};
        n_ops++;
    endtask

    task automatic write_entry(line_addr_t addr, wsel_t wsel, byteen_t be, word_t data);
        ops[n_ops] = '{rw: 1'b1, fill: 1'b0, addr: addr, wsel: wsel, be: be, data: data};
        n_ops++;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + NUM_OPS * OP_CYCLES));
        $display("timeout: the table did not complete in time");
        $display("TEST FAIL");
        $finish;
    end

    // memory model, also drives the random response ready
    initial begin
        lfsr           = 32'haf8b;
        fill_wait      = '0;
        mem_reads      = 0;
        mem_writes     = 0;
        rd_pos         = 0;
        wr_pos         = 0;
        mem_errors     = 0;
        mem_req_ready  = 1'b1;
        mem_rsp_valid  = 1'b0;
        mem_rsp_data   = '0;
        core_rsp_ready = 1'b0;
        for (int l = 0; l < NUM_MEM_LINES; l++) begin
            for (int w = 0; w < LINE_WORDS; w++) begin
                mem_lines[l][w] = pattern_word(line_addr_t'(l), w);
            end
        end
        forever begin
            @(posedge clk);
            lfsr = lfsr_next(lfsr);
            core_rsp_ready <= lfsr[0];
            if (mem_rsp_valid && mem_rsp_ready) begin
                mem_rsp_valid <= 1'b0;
            end else if (!mem_rsp_valid && fill_q.size() != 0) begin
                if (fill_wait == 0) begin
                    mem_rsp_valid <= 1'b1;
                    mem_rsp_data  <= fill_q.pop_front();
                    for (int k = 0; k < 3; k++) begin
                        lfsr = lfsr_next(lfsr);
                        fill_wait[k] = lfsr[0];
                    end
                end else begin
                    fill_wait = fill_wait - 1'b1;
                end
            end
            if (rst_n && mem_req_valid && mem_req_ready) begin
                if (mem_req_rw) begin
                    // write-throughs reach memory in table order
                    while (wr_pos < NUM_OPS && !ops[wr_pos].rw) begin
                        wr_pos++;
                    end
                    if (wr_pos >= NUM_OPS) begin
                        $display("unexpected memory write to line %h at %0t", mem_req_addr, $time);
                        mem_errors++;
                    end else if (mem_req_addr !== ops[wr_pos].addr
                              || mem_req_wsel !== ops[wr_pos].wsel
                              || mem_req_byteen !== ops[wr_pos].be
                              || mem_req_data !== ops[wr_pos].data) begin
                        $display("FAIL %0t: memory write %h/%0d/%h/%h, expected entry %0d",
                                 $time, mem_req_addr, mem_req_wsel, mem_req_byteen,
                                 mem_req_data, wr_pos);
                        mem_errors++;
                    end
                    for (int b = 0; b < WORD_BITS / 8; b++) begin
                        if (mem_req_byteen[b]) begin
                            mem_lines[mem_req_addr][mem_req_wsel][b*8 +: 8] =
                                mem_req_data[b*8 +: 8];
                        end
                    end
                    wr_pos++;
                    mem_writes++;
                end else begin
                    while (rd_pos < NUM_OPS && !ops[rd_pos].fill) begin
                        rd_pos++;
                    end
                    if (rd_pos >= NUM_OPS) begin
                        $display("unexpected memory read of line %h at %0t", mem_req_addr, $time);
                        mem_errors++;
                    end else if (mem_req_addr !== ops[rd_pos].addr) begin
                        $display("FAIL %0t: memory read of line %h, expected %h",
                                 $time, mem_req_addr, ops[rd_pos].addr);
                        mem_errors++;
                    end
                    fill_q.push_back(mem_lines[mem_req_addr]);
                    rd_pos++;
                    mem_reads++;
                end
            end
        end
    end

    // response checker
    initial begin
        int t;
        answered    = 0;
        data_errors = 0;
        for (int i = 0; i < NUM_OPS; i++) begin
            rsp_count[i] = 0;
        end
        forever begin
            @(posedge clk);
            if (rst_n && core_rsp_valid && core_rsp_ready) begin
                t = int'(core_rsp_tag);
                if (t >= NUM_OPS || !issued[t]) begin
                    $display("response with tag %0d that no read issued", t);
                    data_errors++;
                end else begin
                    if (rsp_count[t] != 0) begin
                        $display("tag %0d answered more than once", t);
                        data_errors++;
                    end
                    if (core_rsp_data !== exp_data[t]) begin
                        $display("FAIL %0t: tag %0d data %h, expected %h",
                                 $time, t, core_rsp_data, exp_data[t]);
                        data_errors++;
                    end
                    rsp_count[t]++;
                end
                answered <= answered + 1;
            end
        end
    end

    initial begin
        rst_n           = 1'b0;
        core_req_valid  = 1'b0;
        core_req_rw     = 1'b0;
        core_req_addr   = '0;
        core_req_wsel   = '0;
        core_req_byteen = '0;
        core_req_data   = '0;
        core_req_tag    = '0;
        n_ops           = 0;
        issued_reads    = 0;
        seq_errors      = 0;
        fills_expected  = 0;
        writes_expected = 0;
        for (int l = 0; l < NUM_MEM_LINES; l++) begin
            for (int w = 0; w < LINE_WORDS; w++) begin
                shadow[l][w] = pattern_word(line_addr_t'(l), w);
            end
        end
        for (int i = 0; i < NUM_OPS; i++) begin
            issued[i] = 1'b0;
        end

        // lines 010 and 110 share index 0, 023 and f23 share index 3
        read_entry(12'h010, 2'd0, 1'b1);
        read_entry(12'h010, 2'd1, 1'b0);
        read_entry(12'h010, 2'd3, 1'b0);
        read_entry(12'h023, 2'd2, 1'b1);
        read_entry(12'h023, 2'd0, 1'b0);
        read_entry(12'h010, 2'd2, 1'b0);
        write_entry(12'h010, 2'd1, 4'hf, 32'hdeadbeef);
        read_entry(12'h010, 2'd1, 1'b0);
        write_entry(12'h010, 2'd1, 4'h5, 32'h11223344);
        read_entry(12'h010, 2'd1, 1'b0);
        write_entry(12'h045, 2'd0, 4'h3, 32'hcafef00d);
        read_entry(12'h045, 2'd0, 1'b1);
        read_entry(12'h045, 2'd0, 1'b0);
        read_entry(12'h110, 2'd0, 1'b1);
        read_entry(12'h110, 2'd1, 1'b0);
        read_entry(12'h010, 2'd1, 1'b1);
        read_entry(12'h110, 2'd2, 1'b1);
        read_entry(12'h010, 2'd3, 1'b1);
        write_entry(12'h110, 2'd2, 4'hc, 32'ha5a55a5a);
        read_entry(12'h010, 2'd3, 1'b0);
        read_entry(12'h110, 2'd2, 1'b1);
        read_entry(12'h023, 2'd1, 1'b0);
        read_entry(12'h023, 2'd3, 1'b0);
        read_entry(12'h045, 2'd1, 1'b0);
        read_entry(12'h110, 2'd0, 1'b0);
        read_entry(12'hf23, 2'd1, 1'b1);
        read_entry(12'h023, 2'd1, 1'b1);
        read_entry(12'h110, 2'd3, 1'b0);
        for (int i = 0; i < NUM_OPS; i++) begin
            if (ops[i].fill) begin
                fills_expected++;
            end
            if (ops[i].rw) begin
                writes_expected++;
            end
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        if (core_rsp_valid || mem_req_valid) begin
            $display("response or memory request valid right after reset");
            seq_errors++;
        end

        for (int i = 0; i < NUM_OPS; i++) begin
            core_req_valid  <= 1'b1;
            core_req_rw     <= ops[i].rw;
            core_req_addr   <= ops[i].addr;
            core_req_wsel   <= ops[i].wsel;
            core_req_byteen <= ops[i].be;
            core_req_data   <= ops[i].data;
            core_req_tag    <= req_tag_t'(i);
            do @(posedge clk); while (!core_req_ready);
            if (ops[i].rw) begin
                for (int b = 0; b < WORD_BITS / 8; b++) begin
                    if (ops[i].be[b]) begin
                        shadow[ops[i].addr][ops[i].wsel][b*8 +: 8] = ops[i].data[b*8 +: 8];
                    end
                end
            end else begin
                exp_data[i] = shadow[ops[i].addr][ops[i].wsel];
                issued[i]   = 1'b1;
                issued_reads++;
            end
            // a fetching read drains before the next entry
            if (ops[i].fill) begin
                core_req_valid <= 1'b0;
                do @(posedge clk); while (answered != issued_reads);
            end
        end
        core_req_valid <= 1'b0;
        do @(posedge clk); while (answered != issued_reads || mem_req_valid);

        for (int i = 0; i < NUM_OPS; i++) begin
            if (issued[i] && rsp_count[i] != 1) begin
                $display("tag %0d answered %0d times", i, rsp_count[i]);
                seq_errors++;
            end
        end
        if (fill_q.size() != 0) begin
            $display("memory reads left unanswered at the end");
            seq_errors++;
        end
        if (mem_reads != fills_expected) begin
            $display("FAIL %0t: %0d memory reads, expected %0d line fills",
                     $time, mem_reads, fills_expected);
            seq_errors++;
        end
        if (mem_writes != writes_expected) begin
            $display("FAIL %0t: %0d memory writes, expected %0d",
                     $time, mem_writes, writes_expected);
            seq_errors++;
        end
        $display("errors: data %0d, memory %0d, sequence %0d (fills %0d, writes %0d)",
                 data_errors, mem_errors, seq_errors, fills_expected, writes_expected);
        if (data_errors + mem_errors + seq_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* verilog.f */
source/cache_pkg.sv
source/cache_fifo.sv
source/cache_tags.sv
source/cache_data.sv
source/cache_miss_tracker.sv
source/cache_bank.sv
test/cache_bank_tb.sv

/* Makefile */
SIM        = verilator
TOP        = cache_bank_tb
RTL_TOP    = cache_bank
FILELIST   = verilog.f
BUILD_DIR  = obj_dir
LOG        = sim.log
FLAGS      = --binary --timing --assert -j 0 -Mdir $(BUILD_DIR)
LINT_FLAGS = --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST PASS" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
